// ==== rtl/outrun_io_pkg.sv ====
// Shared bus, select, cabinet and control types for the Out Run I/O glue
// Referenced by scoped name from the RTL and the testbench
`default_nettype none

package outrun_io_pkg;

    // One 68000 bus cycle as seen by the glue logic
    typedef struct packed {
        logic [23:1] addr;      // Word address
        logic        as_n;
        logic        uds_n;
        logic        lds_n;
        logic        rnw;
        logic [2:0]  fc;
        logic [15:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic rom;
        logic ram;
        logic vram;
        logic chr;
        logic pal;
        logic obj;
        logic sub;
        logic io;
    } chip_sel_t;

    typedef struct packed {
        logic [7:0]  joystick1; // Active low buttons
        logic        start;
        logic [1:0]  coin;
        logic        service;
        logic        dip_test;
        logic [7:0]  dipsw_a;
        logic [7:0]  dipsw_b;
        logic [15:0] joyana1;   // Wheel in the low byte
        logic [15:0] joyana1b;
        logic [2:0]  ctrl_type;
    } cab_in_t;

    // Out Run PPI port C
    typedef struct packed {
        logic [1:0] obj_cfg;    // Bit 1 object engine, bit 0 colour mixer
        logic       video_en;
        logic [2:0] adc_ch;
        logic       rsvd;
        logic       snd_rstb;
    } outrun_ctrl_t;

    // Super Hang On control word
    typedef struct packed {
        logic [1:0] adc_ch;
        logic       mute_n;
        logic       video_en;
        logic [2:0] rsvd;
        logic       snd_rstb;
    } shangon_ctrl_t;

    typedef union packed {
        outrun_ctrl_t  outrun;
        shangon_ctrl_t shangon;
    } io_ctrl_u;

    typedef enum logic [1:0] {
        GAME_OUTRUN  = 2'd0,
        GAME_SHANGON = 2'd1
    } game_e;

    // Bits of the mapper region-active vector
    localparam int REG_MEM = 0;
    localparam int REG_SCR = 1;
    localparam int REG_PAL = 2;
    localparam int REG_OBJ = 3;
    localparam int REG_IO  = 4;
    localparam int REG_SUB = 5;

    localparam logic [2:0] FC_IACK     = 3'd7;
    localparam logic [7:0] PORTC_RESET = 8'h21;   // video_en and snd_rstb set

    // Out Run I/O groups on address bits 6..4
    localparam logic [2:0] OR_GRP_PPI  = 3'd0;
    localparam logic [2:0] OR_GRP_IN   = 3'd1;
    localparam logic [2:0] OR_GRP_MUTE = 3'd2;
    localparam logic [2:0] OR_GRP_ADC  = 3'd3;
    localparam logic [2:0] OR_GRP_OBJ  = 3'd7;

    // Super Hang On sub-addresses on address bits 13, 12 and 5
    localparam logic [2:0] SH_SUB_CTRL = 3'd0;
    localparam logic [2:0] SH_SUB_SND  = 3'd1;
    localparam logic [2:0] SH_SUB_IN   = 3'd2;
    localparam logic [2:0] SH_SUB_ADC  = 3'd7;

    localparam logic [2:0] ADC_WHEEL = 3'd0;
    localparam logic [2:0] ADC_GAS   = 3'd1;
    localparam logic [2:0] ADC_BRAKE = 3'd2;

endpackage

`default_nettype wire

// ==== rtl/outrun_region_decode.sv ====
// Chip select decode for the main CPU bus
// Selects register one edge after the request, from the mapper region bits
`timescale 1ns/1ps
`default_nettype none

module outrun_region_decode (
    input  wire                          clk,
    input  wire                          rst,
    input  wire outrun_io_pkg::bus_req_t req,
    input  wire [7:0]                    active,
    output outrun_io_pkg::chip_sel_t     sel
);

    logic strobe;
    logic cyc_ok;

    assign strobe = !(req.uds_n && req.lds_n);   // Either data strobe low
    assign cyc_ok = !req.as_n && req.fc != outrun_io_pkg::FC_IACK;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel <= '0;
        end else if (cyc_ok) begin
            // RAM sits in the top quarter of the memory region
            sel.rom  <= active[outrun_io_pkg::REG_MEM] && req.addr[18:17] != 2'b11;
            sel.ram  <= active[outrun_io_pkg::REG_MEM] && req.addr[18:17] == 2'b11 && strobe;
            sel.chr  <= active[outrun_io_pkg::REG_SCR] && req.addr[16];
            sel.vram <= active[outrun_io_pkg::REG_SCR] && !req.addr[16] && strobe;
            sel.pal  <= active[outrun_io_pkg::REG_PAL];
            sel.obj  <= active[outrun_io_pkg::REG_OBJ];
            sel.io   <= active[outrun_io_pkg::REG_IO];
            sel.sub  <= active[outrun_io_pkg::REG_SUB];
        end else begin
            sel <= '0;   // Bus idle or interrupt acknowledge
        end
    end

endmodule

`default_nettype wire

// ==== rtl/outrun_cab_latch.sv ====
// Cabinet control latches for both games
// Out Run drives its outputs from PPI port C, Super Hang On from its control word
`timescale 1ns/1ps
`default_nettype none

module outrun_cab_latch (
    input  wire                          clk,
    input  wire                          rst,
    input  wire outrun_io_pkg::bus_req_t req,
    input  wire outrun_io_pkg::chip_sel_t sel,
    input  wire outrun_io_pkg::game_e    game,
    output logic [2:0]                   adc_ch,
    output logic [1:0]                   obj_cfg,
    output logic                         video_en,
    output logic                         snd_rstb,
    output logic                         mute,
    output logic [7:0]                   ppi_b,
    output logic [7:0]                   ppi_c
);

    outrun_io_pkg::io_ctrl_u wr_ctrl;   // Written byte
    outrun_io_pkg::io_ctrl_u port_c;
    logic       is_sh;
    logic       wr_lo;
    logic [2:0] or_grp;
    logic [2:0] sh_sub;
    logic [2:0] sh_adc;
    logic       sh_video;
    logic       sh_snd;

    assign is_sh   = game == outrun_io_pkg::GAME_SHANGON;
    assign wr_lo   = sel.io && !req.rnw && !req.lds_n;
    assign or_grp  = req.addr[6:4];
    assign sh_sub  = {req.addr[13:12], req.addr[5]};
    assign wr_ctrl = req.wdata[7:0];
    assign port_c  = ppi_c;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ppi_b    <= '0;
            ppi_c    <= outrun_io_pkg::PORTC_RESET;
            mute     <= 1'b0;
            sh_adc   <= '0;
            sh_video <= 1'b1;
            sh_snd   <= 1'b1;
        end else if (wr_lo && !is_sh) begin
            if (or_grp == outrun_io_pkg::OR_GRP_PPI) begin
                case (req.addr[2:1])
                    2'd1: ppi_b <= req.wdata[7:0];
                    2'd2: ppi_c <= req.wdata[7:0];
                    default: ;   // Port A is an input, mode word ignored
                endcase
            end
            if (or_grp == outrun_io_pkg::OR_GRP_MUTE)
                mute <= !req.wdata[7];   // Inverting darlington driver
        end else if (wr_lo) begin
            if (sh_sub == outrun_io_pkg::SH_SUB_CTRL) begin
                sh_adc   <= {1'b0, wr_ctrl.shangon.adc_ch};
                sh_video <= wr_ctrl.shangon.video_en;
                mute     <= !wr_ctrl.shangon.mute_n;
            end else if (sh_sub == outrun_io_pkg::SH_SUB_SND) begin
                sh_snd <= wr_ctrl.shangon.snd_rstb;
            end
        end
    end

    assign obj_cfg  = is_sh ? 2'b00 : port_c.outrun.obj_cfg;   // No object config on Hang On
    assign video_en = is_sh ? sh_video : port_c.outrun.video_en;
    assign snd_rstb = is_sh ? sh_snd : port_c.outrun.snd_rstb;
    assign adc_ch   = is_sh ? sh_adc : port_c.outrun.adc_ch;

endmodule

`default_nettype wire

// ==== rtl/outrun_adc.sv ====
// Analog control capture and conversion
// A write to the ADC address holds the analog inputs, reads convert the held values
`timescale 1ns/1ps
`default_nettype none

module outrun_adc (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          capture,
    input  wire outrun_io_pkg::game_e    game,
    input  wire outrun_io_pkg::cab_in_t  cab,
    input  wire [2:0]                    adc_ch,
    output logic [7:0]                   adc_dout
);

    logic [15:0] ana_a;   // Held joyana1
    logic [15:0] ana_b;   // Held joyana1b
    logic [7:0]  wheel;
    logic [7:0]  gas;
    logic [7:0]  brake;
    logic        is_sh;

    // Upper half of a signed stick value to an 8-bit pedal
    function automatic logic [7:0] scale(input logic [15:0] v);
        return {v[14:8], v[14]};
    endfunction

    assign is_sh = game == outrun_io_pkg::GAME_SHANGON;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ana_a <= '0;
            ana_b <= '0;
        end else if (capture) begin
            ana_a <= cab.joyana1;
            ana_b <= cab.joyana1b;
        end
    end

    always_comb begin
        // Wheel centred on 0x80, mirrored on Hang On
        wheel = is_sh ? ~ana_a[7:0] ^ 8'h80 : ana_a[7:0] ^ 8'h80;
        if (is_sh) begin
            if (!cab.joystick1[1]) wheel = 8'he0;
            if (!cab.joystick1[0]) wheel = 8'h20;
        end else begin
            if (!cab.joystick1[0]) wheel = 8'he0;
            if (!cab.joystick1[1]) wheel = 8'h20;
        end
        case (cab.ctrl_type)
            3'd0: begin   // Dual analog stick
                gas   = ana_b[15] ? ~scale(ana_b) : 8'd0;
                brake = ana_b[15] ? 8'd0 : scale(ana_b);
            end
            3'd1: begin   // Analog triggers
                gas   = ana_b[7] ? 8'd0 : {ana_b[6:0], ana_b[6]};
                brake = ana_a[15] ? 8'd0 : scale(ana_a);
            end
            3'd2: begin   // Steering wheel with pedals
                gas   = ana_a[15] ? ~scale(ana_a) : 8'd0;
                brake = ana_b[15] ? ~scale(ana_b) : 8'd0;
            end
            default: begin
                gas   = 8'd0;
                brake = 8'd0;
            end
        endcase
        if (!cab.joystick1[4]) gas = 8'hff;     // Button override
        if (!cab.joystick1[5]) brake = 8'hff;
        case (adc_ch)
            outrun_io_pkg::ADC_WHEEL: adc_dout = wheel;
            outrun_io_pkg::ADC_GAS:   adc_dout = gas;
            outrun_io_pkg::ADC_BRAKE: adc_dout = brake;
            default:                  adc_dout = 8'hff;   // Motor channel
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/outrun_cab_read.sv ====
// Cabinet read multiplexer for both games
// Also raises the ADC capture strobe and the Out Run object half strobe
`timescale 1ns/1ps
`default_nettype none

module outrun_cab_read (
    input  wire                          clk,
    input  wire                          rst,
    input  wire outrun_io_pkg::chip_sel_t sel,
    input  wire outrun_io_pkg::bus_req_t req,
    input  wire outrun_io_pkg::game_e    game,
    input  wire outrun_io_pkg::cab_in_t  cab,
    input  wire [2:0]                    adc_ch,
    input  wire [7:0]                    ppi_b,
    input  wire [7:0]                    ppi_c,
    output logic [7:0]                   cab_dout,
    output logic                         obj_half
);

    logic       capture;
    logic [7:0] adc_dout;
    logic       is_sh;
    logic [2:0] or_grp;
    logic [2:0] sh_sub;
    logic [1:0] port;

    assign is_sh  = game == outrun_io_pkg::GAME_SHANGON;
    assign or_grp = req.addr[6:4];
    assign sh_sub = {req.addr[13:12], req.addr[5]};
    assign port   = req.addr[2:1];

    outrun_adc adc_i (
        .clk      (clk),
        .rst      (rst),
        .capture  (capture),
        .game     (game),
        .cab      (cab),
        .adc_ch   (adc_ch),
        .adc_dout (adc_dout)
    );

    always_comb begin
        cab_dout = 8'hff;
        obj_half = 1'b0;
        capture  = 1'b0;
        if (sel.io && is_sh) begin
            case (sh_sub)
                outrun_io_pkg::SH_SUB_IN: begin
                    case (port)
                        2'd1: cab_dout = {2'b11, cab.joystick1[7], cab.start, cab.service,
                                          cab.dip_test, cab.coin};
                        2'd2: cab_dout = cab.dipsw_a;
                        2'd3: cab_dout = cab.dipsw_b;
                        default: ;
                    endcase
                end
                outrun_io_pkg::SH_SUB_ADC: begin
                    cab_dout = adc_dout;
                    capture  = !req.rnw;   // Write starts a conversion
                end
                default: ;
            endcase
        end else if (sel.io) begin
            case (or_grp)
                outrun_io_pkg::OR_GRP_PPI: begin
                    if (port == 2'd1) cab_dout = ppi_b;   // Latch readback
                    if (port == 2'd2) cab_dout = ppi_c;
                end
                outrun_io_pkg::OR_GRP_IN: begin
                    case (port)
                        2'd0: cab_dout = {cab.coin, ~cab.joystick1[7], cab.joystick1[6],
                                          cab.start, cab.service, cab.dip_test, 1'b1};
                        2'd2: cab_dout = cab.dipsw_a;
                        2'd3: cab_dout = cab.dipsw_b;
                        default: ;
                    endcase
                end
                outrun_io_pkg::OR_GRP_ADC: begin
                    cab_dout = adc_dout;
                    capture  = !req.rnw;
                end
                outrun_io_pkg::OR_GRP_OBJ: obj_half = 1'b1;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/outrun_bus_mux.sv ====
// CPU read data selection
// Registers the read word from the chip selects, one edge after the selects
`timescale 1ns/1ps
`default_nettype none

module outrun_bus_mux (
    input  wire                          clk,
    input  wire                          rst,
    input  wire outrun_io_pkg::bus_req_t req,
    input  wire outrun_io_pkg::chip_sel_t sel,
    input  wire [7:0]                    cab_dout,
    input  wire [15:0]                   rom_data,
    input  wire [15:0]                   ram_data,   // RAM and VRAM share it
    input  wire [15:0]                   chr_dout,
    input  wire [15:0]                   pal_dout,
    input  wire [15:0]                   obj_dout,
    input  wire [15:0]                   sub_din,
    output logic [15:0]                  cpu_din
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_din <= '0;
        end else if ((sel.ram && !req.addr[21]) || sel.vram) begin
            cpu_din <= ram_data;
        end else if (sel.rom && !req.addr[21]) begin
            cpu_din <= rom_data;   // Unencrypted ROM
        end else if (sel.chr) begin
            cpu_din <= chr_dout;
        end else if (sel.pal) begin
            cpu_din <= pal_dout;
        end else if (sel.obj) begin
            cpu_din <= obj_dout;
        end else if (sel.sub) begin
            cpu_din <= sub_din;
        end else if (sel.io) begin
            cpu_din <= {8'hff, cab_dout};   // Cabinet I/O is byte wide
        end else begin
            cpu_din <= 16'hffff;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/outrun_io_top.sv ====
// Main board glue seen from the CPU bus
// Chip select decode, cabinet latches and reads, and the read data register
`timescale 1ns/1ps
`default_nettype none

module outrun_io_top (
    input  wire                          clk,
    input  wire                          rst,
    input  wire outrun_io_pkg::bus_req_t req,
    input  wire [7:0]                    active,
    input  wire outrun_io_pkg::game_e    game,
    input  wire outrun_io_pkg::cab_in_t  cab,
    input  wire [15:0]                   rom_data,
    input  wire [15:0]                   ram_data,
    input  wire [15:0]                   chr_dout,
    input  wire [15:0]                   pal_dout,
    input  wire [15:0]                   obj_dout,
    input  wire [15:0]                   sub_din,
    output outrun_io_pkg::chip_sel_t     sel,
    output logic [15:0]                  cpu_din,
    output logic [1:0]                   obj_cfg,
    output logic                         video_en,
    output logic                         snd_rstb,
    output logic                         mute,
    output logic                         obj_half
);

    logic [2:0] adc_ch;
    logic [7:0] ppi_b;
    logic [7:0] ppi_c;
    logic [7:0] cab_dout;

    outrun_region_decode decode_i (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .active (active),
        .sel    (sel)
    );

    outrun_cab_latch latch_i (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .sel      (sel),
        .game     (game),
        .adc_ch   (adc_ch),
        .obj_cfg  (obj_cfg),
        .video_en (video_en),
        .snd_rstb (snd_rstb),
        .mute     (mute),
        .ppi_b    (ppi_b),
        .ppi_c    (ppi_c)
    );

    outrun_cab_read read_i (
        .clk      (clk),
        .rst      (rst),
        .sel      (sel),
        .req      (req),
        .game     (game),
        .cab      (cab),
        .adc_ch   (adc_ch),
        .ppi_b    (ppi_b),
        .ppi_c    (ppi_c),
        .cab_dout (cab_dout),
        .obj_half (obj_half)
    );

    outrun_bus_mux mux_i (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .sel      (sel),
        .cab_dout (cab_dout),
        .rom_data (rom_data),
        .ram_data (ram_data),
        .chr_dout (chr_dout),
        .pal_dout (pal_dout),
        .obj_dout (obj_dout),
        .sub_din  (sub_din),
        .cpu_din  (cpu_din)
    );

endmodule

`default_nettype wire

// ==== include/outrun_io_model.svh ====
// Reference model of the I/O glue for the testbench
// Included inside the testbench module
// The caller keeps the model state
`ifndef OUTRUN_IO_MODEL_SVH
`define OUTRUN_IO_MODEL_SVH

typedef struct packed {
    logic [7:0] ppi_b;
    logic [7:0] ppi_c;
    logic [2:0] sh_adc;
    logic       sh_video;
    logic       sh_snd;
    logic       mute;
} model_ctrl_t;

function automatic outrun_io_pkg::chip_sel_t predict_sel(input outrun_io_pkg::bus_req_t r,
                                                         input logic [7:0] act);
    outrun_io_pkg::chip_sel_t s;
    logic ds;
    s  = '0;
    ds = !(r.uds_n && r.lds_n);
    if (r.as_n || r.fc == outrun_io_pkg::FC_IACK) return s;
    s.rom  = act[outrun_io_pkg::REG_MEM] && r.addr[18:17] != 2'b11;
    s.ram  = act[outrun_io_pkg::REG_MEM] && r.addr[18:17] == 2'b11 && ds;
    s.chr  = act[outrun_io_pkg::REG_SCR] && r.addr[16];
    s.vram = act[outrun_io_pkg::REG_SCR] && !r.addr[16] && ds;
    s.pal  = act[outrun_io_pkg::REG_PAL];
    s.obj  = act[outrun_io_pkg::REG_OBJ];
    s.io   = act[outrun_io_pkg::REG_IO];
    s.sub  = act[outrun_io_pkg::REG_SUB];
    return s;
endfunction

// Low byte write with io selected
function automatic model_ctrl_t apply_write(input model_ctrl_t m, input outrun_io_pkg::game_e g,
                                            input outrun_io_pkg::bus_req_t r);
    outrun_io_pkg::io_ctrl_u c;
    c = r.wdata[7:0];
    if (g != outrun_io_pkg::GAME_SHANGON) begin
        if (r.addr[6:4] == 3'd0 && r.addr[2:1] == 2'd1) m.ppi_b = r.wdata[7:0];
        if (r.addr[6:4] == 3'd0 && r.addr[2:1] == 2'd2) m.ppi_c = r.wdata[7:0];
        if (r.addr[6:4] == 3'd2) m.mute = !r.wdata[7];
    end else if ({r.addr[13:12], r.addr[5]} == 3'd0) begin
        m.sh_adc   = {1'b0, c.shangon.adc_ch};
        m.sh_video = c.shangon.video_en;
        m.mute     = !c.shangon.mute_n;
    end else if ({r.addr[13:12], r.addr[5]} == 3'd1) begin
        m.sh_snd = c.shangon.snd_rstb;
    end
    return m;
endfunction

// Packed as obj_cfg, video_en, snd_rstb, mute, adc_ch
function automatic logic [7:0] pack_outputs(input model_ctrl_t m, input outrun_io_pkg::game_e g);
    outrun_io_pkg::io_ctrl_u c;
    c = m.ppi_c;
    if (g == outrun_io_pkg::GAME_SHANGON) return {2'b00, m.sh_video, m.sh_snd, m.mute, m.sh_adc};
    return {c.outrun.obj_cfg, c.outrun.video_en, c.outrun.snd_rstb, m.mute, c.outrun.adc_ch};
endfunction

function automatic logic [7:0] convert_adc(input outrun_io_pkg::game_e g, input logic [2:0] ch,
                                           input outrun_io_pkg::cab_in_t cab,
                                           input logic [15:0] a, input logic [15:0] b);
    logic       sh;
    logic [7:0] v;
    sh = g == outrun_io_pkg::GAME_SHANGON;
    v  = 8'hff;
    if (ch == 3'd0) begin
        v = sh ? ~a[7:0] ^ 8'h80 : a[7:0] ^ 8'h80;
        if (!cab.joystick1[sh ? 1 : 0]) v = 8'he0;
        if (!cab.joystick1[sh ? 0 : 1]) v = 8'h20;
    end else if (ch == 3'd1) begin
        v = cab.ctrl_type == 3'd0 ? (b[15] ? ~{b[14:8], b[14]} : 8'd0) :
            cab.ctrl_type == 3'd1 ? (b[7] ? 8'd0 : {b[6:0], b[6]}) :
            cab.ctrl_type == 3'd2 ? (a[15] ? ~{a[14:8], a[14]} : 8'd0) : 8'd0;
        if (!cab.joystick1[4]) v = 8'hff;
    end else if (ch == 3'd2) begin
        v = cab.ctrl_type == 3'd0 ? (b[15] ? 8'd0 : {b[14:8], b[14]}) :
            cab.ctrl_type == 3'd1 ? (a[15] ? 8'd0 : {a[14:8], a[14]}) :
            cab.ctrl_type == 3'd2 ? (b[15] ? ~{b[14:8], b[14]} : 8'd0) : 8'd0;
        if (!cab.joystick1[5]) v = 8'hff;
    end
    return v;
endfunction

// Byte returned by an io read given the converted ADC byte
function automatic logic [7:0] read_cab(input model_ctrl_t m, input outrun_io_pkg::game_e g,
                                        input outrun_io_pkg::bus_req_t r,
                                        input outrun_io_pkg::cab_in_t cab,
                                        input logic [7:0] adc);
    logic [2:0] grp;
    logic [1:0] p;
    p = r.addr[2:1];
    if (g == outrun_io_pkg::GAME_SHANGON) begin
        grp = {r.addr[13:12], r.addr[5]};
        if (grp == 3'd7) return adc;
        if (grp != 3'd2) return 8'hff;
        return p == 2'd1 ? {2'b11, cab.joystick1[7], cab.start, cab.service, cab.dip_test,
                            cab.coin} :
               p == 2'd2 ? cab.dipsw_a : p == 2'd3 ? cab.dipsw_b : 8'hff;
    end
    grp = r.addr[6:4];
    if (grp == 3'd3) return adc;
    if (grp == 3'd0) return p == 2'd1 ? m.ppi_b : p == 2'd2 ? m.ppi_c : 8'hff;
    if (grp != 3'd1) return 8'hff;
    return p == 2'd0 ? {cab.coin, ~cab.joystick1[7], cab.joystick1[6], cab.start, cab.service,
                        cab.dip_test, 1'b1} :
           p == 2'd2 ? cab.dipsw_a : p == 2'd3 ? cab.dipsw_b : 8'hff;
endfunction

`endif

// ==== tests/outrun_io_tb.sv ====
// Testbench for the Out Run I/O glue top level
// Random bus cycles from a fixed seed, checked against the model in include/
`timescale 1ns/1ps
`default_nettype none

module outrun_io_tb;

    localparam int N_TX = 3000;

    logic                     clk;
    logic                     rst;
    outrun_io_pkg::bus_req_t  req;
    logic [7:0]               active;
    outrun_io_pkg::game_e     game;
    outrun_io_pkg::cab_in_t   cab;
    logic [15:0]              rom_data;
    logic [15:0]              ram_data;
    logic [15:0]              chr_dout;
    logic [15:0]              pal_dout;
    logic [15:0]              obj_dout;
    logic [15:0]              sub_din;
    outrun_io_pkg::chip_sel_t sel;
    logic [15:0]              cpu_din;
    logic [1:0]               obj_cfg;
    logic                     video_en;
    logic                     snd_rstb;
    logic                     mute;
    logic                     obj_half;

    `include "outrun_io_model.svh"

    model_ctrl_t model;     // Expected latch state
    logic [15:0] held_a;    // Expected ADC capture
    logic [15:0] held_b;

    outrun_io_top dut_i (.*);

    always #20 clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [15:0] exp,
                               input logic [15:0] got);
        assert (got === exp) else
            stop_run($sformatf("Error: %s expected %h actual %h", name, exp, got));
    endtask

    // Each falling edge must come within 100 ns
    task automatic wait_falls(input int n);
        realtime start;
        for (int i = 0; i < n; i++) begin
            start = $realtime;
            fork
                @(negedge clk);
                #100;
            join_any
            if ($realtime - start >= 100.0)
                stop_run("Timeout: no falling clock edge within 100 ns");
        end
    endtask

    // Read word priority of the bus mux
    function automatic logic [15:0] expect_din(input outrun_io_pkg::chip_sel_t s,
                                               input outrun_io_pkg::bus_req_t r,
                                               input logic [7:0] cab_byte);
        if ((s.ram && !r.addr[21]) || s.vram) return ram_data;
        if (s.rom && !r.addr[21]) return rom_data;
        if (s.chr) return chr_dout;
        if (s.pal) return pal_dout;
        if (s.obj) return obj_dout;
        if (s.sub) return sub_din;
        if (s.io) return {8'hff, cab_byte};
        return 16'hffff;
    endfunction

    task automatic drive_idle();
        req       = '0;
        req.as_n  = 1'b1;
        req.uds_n = 1'b1;
        req.lds_n = 1'b1;
        req.rnw   = 1'b1;   // No write reaches the latches between cycles
    endtask

    task automatic drive_random();
        logic [31:0] ra;
        logic [31:0] rb;
        logic [31:0] rc;
        logic [31:0] rd;
        ra = $urandom;
        rb = $urandom;
        rc = $urandom;
        rd = $urandom;
        req.addr  = ra[22:0];
        req.wdata = rb[31:16];
        req.fc    = rb[2:0];
        req.as_n  = rb[3] & rb[4];
        req.uds_n = rb[5];
        req.lds_n = rb[6];
        req.rnw   = rb[7];
        active    = rb[15:8];
        game      = outrun_io_pkg::game_e'(ra[24:23]);
        if (ra[26:25] != 2'd0) begin   // Three in four cycles hit cabinet I/O
            active                        = '0;
            active[outrun_io_pkg::REG_IO] = 1'b1;
            req.as_n                      = 1'b0;
            req.fc                        = 3'd5;
            req.lds_n                     = rb[6] & rb[5];   // Mostly low byte
        end
        cab      = {rc, rd};
        rc       = $urandom;
        rd       = $urandom;
        rom_data = rc[15:0];
        ram_data = rc[31:16];
        chr_dout = rd[15:0];
        pal_dout = rd[31:16];
        rc       = $urandom;
        obj_dout = rc[15:0];
        sub_din  = rc[31:16];
    endtask

    task automatic run_cycle();
        outrun_io_pkg::chip_sel_t exp_sel;
        logic [7:0]               outs;
        logic [7:0]               exp_cab;
        logic [15:0]              exp_din;
        logic                     exp_half;
        logic                     adc_hit;
        drive_random();
        outs     = pack_outputs(model, game);
        exp_sel  = predict_sel(req, active);
        exp_cab  = read_cab(model, game, req, cab,
                            convert_adc(game, outs[2:0], cab, held_a, held_b));
        exp_din  = expect_din(exp_sel, req, exp_cab);
        exp_half = exp_sel.io && game != outrun_io_pkg::GAME_SHANGON
                   && req.addr[6:4] == outrun_io_pkg::OR_GRP_OBJ;
        wait_falls(1);   // Edge N
        check_value("chip_sel", {8'h00, exp_sel}, {8'h00, sel});
        check_value("obj_half", {15'd0, exp_half}, {15'd0, obj_half});
        if (exp_sel.io && !req.rnw) begin
            if (!req.lds_n)
                model = apply_write(model, game, req);
            if (game == outrun_io_pkg::GAME_SHANGON)
                adc_hit = {req.addr[13:12], req.addr[5]} == outrun_io_pkg::SH_SUB_ADC;
            else
                adc_hit = req.addr[6:4] == outrun_io_pkg::OR_GRP_ADC;
            if (adc_hit) begin
                held_a = cab.joyana1;
                held_b = cab.joyana1b;
            end
        end
        outs = pack_outputs(model, game);
        wait_falls(1);   // Edge N+1
        check_value("read_data", exp_din, cpu_din);
        check_value("ctrl_out", {11'd0, outs[7:3]}, {11'd0, obj_cfg, video_en, snd_rstb, mute});
        wait_falls(2);
        drive_idle();
        wait_falls(1);
    endtask

    initial begin
        void'($urandom(58935));
        clk = 1'b0;
        rst = 1'b1;
        drive_idle();
        active   = '0;
        game     = outrun_io_pkg::GAME_OUTRUN;
        cab      = '0;
        rom_data = '0;
        ram_data = '0;
        chr_dout = '0;
        pal_dout = '0;
        obj_dout = '0;
        sub_din  = '0;
        model          = '0;
        model.ppi_c    = outrun_io_pkg::PORTC_RESET;
        model.sh_video = 1'b1;
        model.sh_snd   = 1'b1;
        held_a = '0;
        held_b = '0;
        wait_falls(3);
        check_value("reset_sel", 16'h0000, {8'h00, sel});
        check_value("reset_din", 16'h0000, cpu_din);
        check_value("reset_ctrl", 16'h0006, {11'd0, obj_cfg, video_en, snd_rstb, mute});
        rst = 1'b0;
        wait_falls(1);
        for (int i = 0; i < N_TX; i++)
            run_cycle();
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+include
rtl/outrun_io_pkg.sv
rtl/outrun_region_decode.sv
rtl/outrun_cab_latch.sv
rtl/outrun_adc.sv
rtl/outrun_cab_read.sv
rtl/outrun_bus_mux.sv
rtl/outrun_io_top.sv
tests/outrun_io_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile with Verilator and run the testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module outrun_io_tb -f list.f -o outrun_io_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

out=$(./obj_dir/outrun_io_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "All tests passed"; then
    exit 0
fi
echo "Pass message not found in the simulation output"
exit 1
